// ==== source/cpu_bus_pkg.sv ====
// Memory bus definitions of the 4-bit CPU
// Data nibble type, pointer width and default address width
package cpu_bus_pkg;

	localparam int NIBBLE_W = 4;

	// Width of the pointer formed by r6, r5 and r4
	localparam int PTR_W = 12;

	// Address bus width unless the top level overrides it
	localparam int DEF_ADDR_W = 11;

	typedef logic [NIBBLE_W-1:0] nibble_t;

endpackage

// ==== source/cpu_isa_pkg.sv ====
// Instruction set of the 4-bit CPU
// Opcodes, option codes, ALU operations, flag positions and instruction layout
package cpu_isa_pkg;

	typedef enum logic [3:0] {
		OP_MOV      = 4'b0000,
		OP_STO      = 4'b0001,
		OP_LD       = 4'b0010,
		OP_ADD_INC  = 4'b0011,
		OP_ADC      = 4'b0100,
		OP_SUB_DEC  = 4'b0101,
		OP_SBB      = 4'b0110,
		OP_SHLR     = 4'b0111,
		OP_NAND_NOR = 4'b1000,
		OP_AND_OR   = 4'b1001,
		OP_XOR_NOT  = 4'b1010,
		OP_JMP      = 4'b1011,
		OP_JNZ      = 4'b1100,
		OP_JNC_JNB  = 4'b1101,
		OP_JNL      = 4'b1110,
		OP_LDI      = 4'b1111
	} opcode_e;

	// Option field values that select the second form of an opcode
	localparam logic [1:0] OPT_SHR = 2'b01;
	localparam logic [1:0] OPT_ALT = 2'b10;   // INC, NOR, OR, NOT, JNB
	localparam logic [1:0] OPT_DEC = 2'b11;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_ADC  = 4'b0001,
		ALU_SUB  = 4'b0010,
		ALU_SBB  = 4'b0011,
		ALU_SHL  = 4'b0100,
		ALU_SHR  = 4'b0101,
		ALU_AND  = 4'b0110,
		ALU_OR   = 4'b0111,
		ALU_NOT  = 4'b1000,
		ALU_XOR  = 4'b1001,
		ALU_NAND = 4'b1010,
		ALU_NOR  = 4'b1011
	} alu_op_e;

	typedef struct packed {
		opcode_e    opcode;
		logic [1:0] option;
		logic [2:0] arg1;
		logic [2:0] arg2;
	} instr_reg_t;

	typedef struct packed {
		opcode_e    opcode;
		logic [3:0] imm;
		logic       spare;
		logic [2:0] dst;
	} instr_imm_t;

	typedef union packed {
		instr_reg_t reg_view;
		instr_imm_t imm_view;   // Only for LDI
	} instr_u;

	localparam int FLAG_C = 0;
	localparam int FLAG_B = 1;
	localparam int FLAG_Z = 2;
	localparam int FLAG_N = 3;

	localparam logic [2:0] REG_FLAGS = 3'd3;
	localparam logic [2:0] REG_PTR0  = 3'd4;
	localparam logic [2:0] REG_PTR1  = 3'd5;
	localparam logic [2:0] REG_PTR2  = 3'd6;

endpackage

// ==== source/cpu_alu.sv ====
// 4-bit ALU of the CPU
// Combinational result and C, B, Z, N flags, carry and borrow in from flags
`timescale 1ns/1ns

module cpu_alu (
	input  cpu_isa_pkg::alu_op_e op_i,
	input  cpu_bus_pkg::nibble_t a_i,
	input  cpu_bus_pkg::nibble_t b_i,
	input  cpu_bus_pkg::nibble_t flags_i,
	input  logic                 one_b_i,
	output cpu_bus_pkg::nibble_t result_o,
	output cpu_bus_pkg::nibble_t flags_o
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	nibble_t    b_eff;
	logic       carry_in;
	logic       borrow_in;
	logic [4:0] sum;
	logic [4:0] diff;
	logic       carry;
	logic       borrow;

	assign b_eff = one_b_i ? 4'd1 : b_i;   // INC and DEC
	assign carry_in = (op_i == ALU_ADC) && flags_i[FLAG_C];
	assign borrow_in = (op_i == ALU_SBB) && flags_i[FLAG_B];
	assign sum = {1'b0, a_i} + {1'b0, b_eff} + {4'b0, carry_in};
	assign diff = {1'b0, a_i} - {1'b0, b_eff} - {4'b0, borrow_in};

	always_comb begin
		result_o = sum[3:0];
		carry = 1'b0;
		borrow = 1'b0;
		case (op_i)
			ALU_ADD, ALU_ADC: begin
				result_o = sum[3:0];
				carry = sum[4];
			end
			ALU_SUB, ALU_SBB: begin
				result_o = diff[3:0];
				borrow = diff[4];
			end
			ALU_SHL: {carry, result_o} = {a_i, 1'b0};
			ALU_SHR: {result_o, carry} = {1'b0, a_i};
			ALU_AND: result_o = a_i & b_eff;
			ALU_OR: result_o = a_i | b_eff;
			ALU_XOR: result_o = a_i ^ b_eff;
			ALU_NOT: result_o = ~a_i;
			ALU_NAND: result_o = ~(a_i & b_eff);
			ALU_NOR: result_o = ~(a_i | b_eff);
			default: ;
		endcase
	end

	always_comb begin
		flags_o = '0;
		flags_o[FLAG_C] = carry;
		flags_o[FLAG_B] = borrow;
		flags_o[FLAG_Z] = (result_o == 4'd0);
		flags_o[FLAG_N] = result_o[3];
	end

endmodule

// ==== source/cpu_reg_file.sv ====
// Register file of the 4-bit CPU
// Eight nibbles, r3 holds the flags and r6..r4 form the memory pointer
`timescale 1ns/1ns

module cpu_reg_file (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [2:0]                    rd_addr_a_i,
	input  logic [2:0]                    rd_addr_b_i,
	output cpu_bus_pkg::nibble_t          rd_data_a_o,
	output cpu_bus_pkg::nibble_t          rd_data_b_o,
	input  logic                          wr_en_i,
	input  logic [2:0]                    wr_addr_i,
	input  cpu_bus_pkg::nibble_t          wr_data_i,
	input  logic                          flags_we_i,
	input  cpu_bus_pkg::nibble_t          flags_i,
	output cpu_bus_pkg::nibble_t          flags_o,
	output logic [cpu_bus_pkg::PTR_W-1:0] ptr_o
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	nibble_t regs_q [8];

	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int i = 0; i < 8; i++)
				regs_q[i] <= '0;
		end else begin
			if (wr_en_i)
				regs_q[wr_addr_i] <= wr_data_i;
			if (flags_we_i)
				regs_q[REG_FLAGS] <= flags_i;   // Flags win over a result to r3
		end
	end

	assign rd_data_a_o = regs_q[rd_addr_a_i];
	assign rd_data_b_o = regs_q[rd_addr_b_i];
	assign flags_o = regs_q[REG_FLAGS];

	// Full 12 bits, the sequencer cuts to the address width
	assign ptr_o = {regs_q[REG_PTR2], regs_q[REG_PTR1], regs_q[REG_PTR0]};

endmodule

// ==== source/cpu_sequencer.sv ====
// Instruction sequencer of the 4-bit CPU
// Fetches three nibbles per instruction, decodes them, drives register writes,
// the program counter and the valid/ready memory bus
`timescale 1ns/1ns

module cpu_sequencer #(
	parameter int ADDR_W = cpu_bus_pkg::DEF_ADDR_W
) (
	input  logic                             clk,
	input  logic                             rst_n,
	output logic                             mem_req_valid_o,
	output logic                             mem_req_we_o,
	output logic [ADDR_W-1:0]                mem_req_addr_o,
	output cpu_bus_pkg::nibble_t             mem_req_wdata_o,
	input  logic                             mem_req_ready_i,
	input  logic                             mem_rsp_valid_i,
	input  cpu_bus_pkg::nibble_t             mem_rsp_data_i,
	output logic [2:0]                       rd_addr_a_o,
	output logic [2:0]                       rd_addr_b_o,
	input  cpu_bus_pkg::nibble_t             rd_data_a_i,
	input  cpu_bus_pkg::nibble_t             rd_data_b_i,
	output logic                             wr_en_o,
	output logic [2:0]                       wr_addr_o,
	output cpu_bus_pkg::nibble_t             wr_data_o,
	output logic                             flags_we_o,
	output cpu_bus_pkg::nibble_t             flags_o,
	input  cpu_bus_pkg::nibble_t             flags_i,
	input  logic [cpu_bus_pkg::PTR_W-1:0]    ptr_i,
	output cpu_isa_pkg::alu_op_e             alu_op_o,
	output logic                             alu_one_b_o,
	input  cpu_bus_pkg::nibble_t             alu_result_i,
	input  cpu_bus_pkg::nibble_t             alu_flags_i
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	typedef enum logic [2:0] {
		ST_FETCH0,
		ST_FETCH1,
		ST_FETCH2,
		ST_EXEC,
		ST_MEM
	} state_e;

	state_e            state_q;
	logic              wait_rsp_q;   // Read accepted, response still due
	instr_u            instr_q;
	logic [ADDR_W-1:0] pc_q;

	opcode_e           opcode;
	logic [1:0]        option;
	logic [2:0]        arg1;
	logic [2:0]        arg2;
	logic [2:0]        dst;
	logic              is_alu;
	logic              jump_taken;
	logic              in_fetch;
	logic              fetch_issue;
	logic              mem_issue;
	logic              req_done;
	logic              rsp_done;
	logic [ADDR_W-1:0] ptr_addr;

	assign opcode = instr_q.reg_view.opcode;
	assign option = instr_q.reg_view.option;
	assign arg1 = instr_q.reg_view.arg1;
	assign arg2 = instr_q.reg_view.arg2;
	assign ptr_addr = ptr_i[ADDR_W-1:0];

	assign in_fetch = (state_q == ST_FETCH0) || (state_q == ST_FETCH1) || (state_q == ST_FETCH2);
	assign fetch_issue = in_fetch && !mem_req_valid_o && !wait_rsp_q;
	assign mem_issue = (state_q == ST_EXEC) && ((opcode == OP_LD) || (opcode == OP_STO));
	assign req_done = mem_req_valid_o && mem_req_ready_i;
	assign rsp_done = wait_rsp_q && mem_rsp_valid_i;

	// Operand selection, ALU operation and destination
	always_comb begin
		rd_addr_a_o = arg1;
		rd_addr_b_o = arg2;
		alu_op_o = ALU_ADD;
		alu_one_b_o = 1'b0;
		is_alu = 1'b1;
		dst = arg1;
		case (opcode)
			OP_ADD_INC: begin
				if (option == OPT_ALT) begin   // INC
					rd_addr_a_o = arg2;
					alu_one_b_o = 1'b1;
					dst = arg2;
				end
			end
			OP_ADC: alu_op_o = ALU_ADC;
			OP_SUB_DEC: begin
				alu_op_o = ALU_SUB;
				if (option == OPT_DEC) begin
					rd_addr_a_o = arg2;
					alu_one_b_o = 1'b1;
					dst = arg2;
				end
			end
			OP_SBB: alu_op_o = ALU_SBB;
			OP_SHLR: begin
				alu_op_o = (option == OPT_SHR) ? ALU_SHR : ALU_SHL;
				rd_addr_a_o = arg2;
				dst = arg2;
			end
			OP_NAND_NOR: alu_op_o = (option == OPT_ALT) ? ALU_NOR : ALU_NAND;
			OP_AND_OR: alu_op_o = (option == OPT_ALT) ? ALU_OR : ALU_AND;
			OP_XOR_NOT: begin
				if (option == OPT_ALT) begin
					alu_op_o = ALU_NOT;
					rd_addr_a_o = arg2;
					dst = arg2;
				end else begin
					alu_op_o = ALU_XOR;
				end
			end
			OP_MOV, OP_LD: begin
				is_alu = 1'b0;
				dst = arg2;
			end
			OP_LDI: begin
				is_alu = 1'b0;
				dst = instr_q.imm_view.dst;
			end
			default: is_alu = 1'b0;   // STO and jumps
		endcase
	end

	always_comb begin
		case (opcode)
			OP_JMP: jump_taken = 1'b1;
			OP_JNZ: jump_taken = !flags_i[FLAG_Z];
			OP_JNC_JNB: jump_taken = (option == OPT_ALT) ? !flags_i[FLAG_B] : !flags_i[FLAG_C];
			OP_JNL: jump_taken = !flags_i[FLAG_N];
			default: jump_taken = 1'b0;
		endcase
	end

	// Register write port, LD result lands on its response
	always_comb begin
		wr_en_o = 1'b0;
		wr_addr_o = dst;
		wr_data_o = alu_result_i;
		if (state_q == ST_EXEC) begin
			case (opcode)
				OP_MOV: begin
					wr_en_o = 1'b1;
					wr_data_o = rd_data_a_i;
				end
				OP_LDI: begin
					wr_en_o = 1'b1;
					wr_data_o = instr_q.imm_view.imm;
				end
				default: wr_en_o = is_alu;
			endcase
		end else if ((state_q == ST_MEM) && rsp_done) begin
			wr_en_o = 1'b1;
			wr_data_o = mem_rsp_data_i;
		end
	end

	assign flags_we_o = (state_q == ST_EXEC) && is_alu;
	assign flags_o = alu_flags_i;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			state_q <= ST_FETCH0;
			wait_rsp_q <= 1'b0;
			pc_q <= '0;
			mem_req_valid_o <= 1'b0;
			mem_req_we_o <= 1'b0;
		end else begin
			case (state_q)
				ST_FETCH0, ST_FETCH1, ST_FETCH2: begin
					if (fetch_issue)
						mem_req_valid_o <= 1'b1;
					if (req_done) begin
						mem_req_valid_o <= 1'b0;
						wait_rsp_q <= 1'b1;
					end
					if (rsp_done) begin
						wait_rsp_q <= 1'b0;
						pc_q <= pc_q + 1'b1;
						case (state_q)
							ST_FETCH0: state_q <= ST_FETCH1;
							ST_FETCH1: state_q <= ST_FETCH2;
							default: state_q <= ST_EXEC;
						endcase
					end
				end
				ST_EXEC: begin
					if (mem_issue) begin
						mem_req_valid_o <= 1'b1;
						mem_req_we_o <= (opcode == OP_STO);
						state_q <= ST_MEM;
					end else begin
						if (jump_taken)
							pc_q <= ptr_addr;
						state_q <= ST_FETCH0;
					end
				end
				ST_MEM: begin
					if (req_done) begin
						mem_req_valid_o <= 1'b0;
						mem_req_we_o <= 1'b0;
						if (mem_req_we_o)
							state_q <= ST_FETCH0;   // Write done on handshake
						else
							wait_rsp_q <= 1'b1;
					end
					if (rsp_done) begin
						wait_rsp_q <= 1'b0;
						state_q <= ST_FETCH0;
					end
				end
				default: state_q <= ST_FETCH0;
			endcase
		end
	end

	// Request payload and instruction nibbles
	always_ff @(posedge clk) begin
		if (fetch_issue) begin
			mem_req_addr_o <= pc_q;
		end else if (mem_issue) begin
			mem_req_addr_o <= ptr_addr;
			mem_req_wdata_o <= rd_data_b_i;
		end
		if (rsp_done) begin
			case (state_q)
				ST_FETCH0: instr_q[11:8] <= mem_rsp_data_i;
				ST_FETCH1: instr_q[7:4] <= mem_rsp_data_i;
				ST_FETCH2: instr_q[3:0] <= mem_rsp_data_i;
				default: ;
			endcase
		end
	end

endmodule

// ==== source/cpu_top.sv ====
// 4-bit multicycle CPU top level
// Connects sequencer, register file and ALU, and exposes the memory bus
`timescale 1ns/1ns

module cpu_top #(
	parameter int ADDR_W = cpu_bus_pkg::DEF_ADDR_W
) (
	input  logic                 clk,
	input  logic                 rst_n,
	output logic                 mem_req_valid_o,
	output logic                 mem_req_we_o,
	output logic [ADDR_W-1:0]    mem_req_addr_o,
	output cpu_bus_pkg::nibble_t mem_req_wdata_o,
	input  logic                 mem_req_ready_i,
	input  logic                 mem_rsp_valid_i,
	input  cpu_bus_pkg::nibble_t mem_rsp_data_i
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	logic [2:0]       rd_addr_a;
	logic [2:0]       rd_addr_b;
	nibble_t          rd_data_a;
	nibble_t          rd_data_b;
	logic             wr_en;
	logic [2:0]       wr_addr;
	nibble_t          wr_data;
	logic             flags_we;
	nibble_t          flags_new;
	nibble_t          flags_cur;
	logic [PTR_W-1:0] ptr;
	alu_op_e          alu_op;
	logic             alu_one_b;
	nibble_t          alu_result;
	nibble_t          alu_flags;

	cpu_sequencer #(
		.ADDR_W(ADDR_W)
	) seq_i (
		.clk(clk),
		.rst_n(rst_n),
		.mem_req_valid_o(mem_req_valid_o),
		.mem_req_we_o(mem_req_we_o),
		.mem_req_addr_o(mem_req_addr_o),
		.mem_req_wdata_o(mem_req_wdata_o),
		.mem_req_ready_i(mem_req_ready_i),
		.mem_rsp_valid_i(mem_rsp_valid_i),
		.mem_rsp_data_i(mem_rsp_data_i),
		.rd_addr_a_o(rd_addr_a),
		.rd_addr_b_o(rd_addr_b),
		.rd_data_a_i(rd_data_a),
		.rd_data_b_i(rd_data_b),
		.wr_en_o(wr_en),
		.wr_addr_o(wr_addr),
		.wr_data_o(wr_data),
		.flags_we_o(flags_we),
		.flags_o(flags_new),
		.flags_i(flags_cur),
		.ptr_i(ptr),
		.alu_op_o(alu_op),
		.alu_one_b_o(alu_one_b),
		.alu_result_i(alu_result),
		.alu_flags_i(alu_flags)
	);

	cpu_reg_file regs_i (
		.clk(clk),
		.rst_n(rst_n),
		.rd_addr_a_i(rd_addr_a),
		.rd_addr_b_i(rd_addr_b),
		.rd_data_a_o(rd_data_a),
		.rd_data_b_o(rd_data_b),
		.wr_en_i(wr_en),
		.wr_addr_i(wr_addr),
		.wr_data_i(wr_data),
		.flags_we_i(flags_we),
		.flags_i(flags_new),
		.flags_o(flags_cur),
		.ptr_o(ptr)
	);

	cpu_alu alu_i (
		.op_i(alu_op),
		.a_i(rd_data_a),
		.b_i(rd_data_b),
		.flags_i(flags_cur),
		.one_b_i(alu_one_b),
		.result_o(alu_result),
		.flags_o(alu_flags)
	);

endmodule

// ==== dv/cpu_mem_model.sv ====
// Memory model for the CPU testbench
// 2048 nibbles with random ready and 1 to 4 cycle read latency,
// reports every accepted transfer to the testbench
`timescale 1ns/1ns

module cpu_mem_model #(
	parameter int ADDR_W = cpu_bus_pkg::DEF_ADDR_W
) (
	input  logic                 clk,
	input  logic                 req_valid_i,
	input  logic                 req_we_i,
	input  logic [ADDR_W-1:0]    req_addr_i,
	input  cpu_bus_pkg::nibble_t req_wdata_i,
	output logic                 req_ready_o,
	output logic                 rsp_valid_o,
	output cpu_bus_pkg::nibble_t rsp_data_o,
	input  logic                 rnd_ready_i,
	input  logic [1:0]           rnd_lat_i,
	output logic                 log_valid_o,
	output logic                 log_we_o,
	output logic [ADDR_W-1:0]    log_addr_o,
	output cpu_bus_pkg::nibble_t log_data_o
);
	import cpu_bus_pkg::*;

	nibble_t           mem_q [2048];
	logic              hs;
	logic              hs_we;
	logic [ADDR_W-1:0] hs_addr;
	nibble_t           hs_data;
	nibble_t           rd_data;
	logic              rdy_next;
	int                cnt;

	initial begin
		req_ready_o = 1'b0;
		rsp_valid_o = 1'b0;
		rsp_data_o = '0;
		log_valid_o = 1'b0;
		log_we_o = 1'b0;
		log_addr_o = '0;
		log_data_o = '0;
		cnt = 0;
		forever begin
			@(negedge clk);   // Bus is stable here
			hs = req_valid_i && req_ready_o;
			hs_we = req_we_i;
			hs_addr = req_addr_i;
			hs_data = req_we_i ? req_wdata_i : mem_q[req_addr_i];
			rdy_next = rnd_ready_i;
			if (hs) begin
				if (req_we_i) begin
					mem_q[req_addr_i] = req_wdata_i;
				end else begin
					rd_data = mem_q[req_addr_i];
					cnt = int'(rnd_lat_i) + 1;
				end
			end
			@(posedge clk);
			#1;
			log_valid_o = hs;
			log_we_o = hs_we;
			log_addr_o = hs_addr;
			log_data_o = hs_data;
			req_ready_o = rdy_next;
			rsp_valid_o = 1'b0;
			if (cnt > 0) begin
				cnt = cnt - 1;
				if (cnt == 0) begin
					rsp_valid_o = 1'b1;
					rsp_data_o = rd_data;
				end
			end
		end
	end

endmodule

// ==== dv/tb_top.sv ====
// Testbench for the 4-bit CPU
// Random program, reference execution and check of all reads and stores
`timescale 1ns/1ns

module tb_top;
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	localparam int ADDR_W = DEF_ADDR_W;

	logic              clk;
	logic              rst_n;
	logic              req_valid;
	logic              req_we;
	logic [ADDR_W-1:0] req_addr;
	nibble_t           req_wdata;
	logic              req_ready;
	logic              rsp_valid;
	nibble_t           rsp_data;
	logic              rnd_ready;
	logic [1:0]        rnd_lat;
	logic              log_valid;
	logic              log_we;
	logic [ADDR_W-1:0] log_addr;
	nibble_t           log_data;

	logic [15:0]       lfsr_q;
	nibble_t           img [2048];
	nibble_t           ref_mem [2048];
	int                gen_addr;
	logic [10:0]       halt_addr;
	logic [10:0]       exp_reads [$];
	logic [10:0]       exp_store_addr [$];
	nibble_t           exp_store_data [$];
	int                cycles;

	cpu_top #(.ADDR_W(ADDR_W)) dut_i (
		.clk(clk), .rst_n(rst_n),
		.mem_req_valid_o(req_valid), .mem_req_we_o(req_we),
		.mem_req_addr_o(req_addr), .mem_req_wdata_o(req_wdata),
		.mem_req_ready_i(req_ready), .mem_rsp_valid_i(rsp_valid),
		.mem_rsp_data_i(rsp_data)
	);

	cpu_mem_model #(.ADDR_W(ADDR_W)) mem_i (
		.clk(clk), .req_valid_i(req_valid), .req_we_i(req_we),
		.req_addr_i(req_addr), .req_wdata_i(req_wdata),
		.req_ready_o(req_ready), .rsp_valid_o(rsp_valid), .rsp_data_o(rsp_data),
		.rnd_ready_i(rnd_ready), .rnd_lat_i(rnd_lat),
		.log_valid_o(log_valid), .log_we_o(log_we),
		.log_addr_o(log_addr), .log_data_o(log_data)
	);

	// Galois LFSR stepped once for each of up to four bits
	function automatic logic [3:0] rand_nibble(input int n);
		logic [3:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[2:0], lfsr_q[0]};
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
		end
		return v;
	endfunction

	function automatic logic [2:0] pick_reg();
		logic [1:0] s;
		s = 2'(rand_nibble(2));
		return (s == 2'd3) ? 3'd7 : {1'b0, s};
	endfunction

	task automatic put_instr(input logic [11:0] w);
		img[gen_addr] = w[11:8];
		img[gen_addr + 1] = w[7:4];
		img[gen_addr + 2] = w[3:0];
		gen_addr = gen_addr + 3;
	endtask

	task automatic put_reg(input logic [3:0] op, input logic [1:0] opt,
		input logic [2:0] a1, input logic [2:0] a2);
		put_instr({op, opt, a1, a2});
	endtask

	task automatic put_ldi(input logic [2:0] dst, input logic [3:0] imm);
		put_instr({OP_LDI, imm, 1'b0, dst});
	endtask

	task automatic set_ptr(input logic [10:0] a);
		put_ldi(REG_PTR2, {1'b0, a[10:8]});
		put_ldi(REG_PTR1, a[7:4]);
		put_ldi(REG_PTR0, a[3:0]);
	endtask

	task automatic put_store(input logic [2:0] src);
		put_ldi(REG_PTR0, rand_nibble(4));   // New slot in the data region
		put_reg(OP_STO, 2'b00, 3'd0, src);
	endtask

	task automatic put_alu(output logic [2:0] dst);
		logic [3:0] op;
		logic [1:0] opt;
		logic       alt;
		logic [2:0] a1;
		logic [2:0] a2;
		op = 4'd3 + rand_nibble(3);
		alt = (rand_nibble(1) != 4'd0);
		a1 = pick_reg();
		a2 = pick_reg();
		case (op)
			OP_ADD_INC, OP_NAND_NOR, OP_AND_OR, OP_XOR_NOT: opt = alt ? 2'b10 : 2'b00;
			OP_SUB_DEC: opt = alt ? 2'b11 : 2'b00;
			OP_SHLR: opt = alt ? 2'b01 : 2'b00;
			default: opt = 2'b00;
		endcase
		put_reg(op, opt, a1, a2);
		dst = ((alt && (op == OP_ADD_INC || op == OP_SUB_DEC || op == OP_XOR_NOT)) ||
			op == OP_SHLR) ? a2 : a1;
	endtask

	task automatic gen_program();
		logic [2:0]  d;
		logic [3:0]  kind;
		logic [3:0]  jop;
		logic [1:0]  jopt;
		logic [10:0] t;
		for (int i = 0; i < 2048; i++)
			img[i] = 4'(i) ^ 4'(i >> 4) ^ 4'(i >> 8);   // Fill depends on whole address
		gen_addr = 0;
		put_ldi(3'd0, rand_nibble(4));
		put_ldi(3'd1, rand_nibble(4));
		put_ldi(3'd2, rand_nibble(4));
		put_ldi(3'd7, rand_nibble(4));
		set_ptr(11'h400);
		for (int n = 0; n < 28; n++) begin
			kind = rand_nibble(3);
			if (kind < 4'd4) begin
				put_alu(d);
				put_store(d);
				put_store(REG_FLAGS);
			end else if (kind == 4'd4) begin
				d = pick_reg();
				put_reg(OP_MOV, 2'b00, pick_reg(), d);
				put_store(d);
			end else if (kind == 4'd5) begin
				d = pick_reg();
				put_ldi(REG_PTR0, rand_nibble(4));
				put_reg(OP_LD, 2'b00, 3'd0, d);
				put_store(d);
			end else begin
				put_alu(d);   // Flags for the guard
				case (rand_nibble(2))
					4'd0: begin
						jop = OP_JNZ;
						jopt = 2'b00;
					end
					4'd1: begin
						jop = OP_JNC_JNB;
						jopt = 2'b00;
					end
					4'd2: begin
						jop = OP_JNC_JNB;
						jopt = 2'b10;
					end
					default: begin
						jop = OP_JNL;
						jopt = 2'b00;
					end
				endcase
				t = 11'(gen_addr + 15);   // Past the guarded INC
				set_ptr(t);
				put_reg(jop, jopt, 3'd0, 3'd0);
				put_reg(OP_ADD_INC, 2'b10, 3'd0, 3'd7);
				set_ptr(11'h400);
				put_store(3'd7);
			end
		end
		halt_addr = 11'(gen_addr + 9);
		set_ptr(halt_addr);
		put_reg(OP_JMP, 2'b00, 3'd0, 3'd0);
	endtask

	// Expected ALU result in [3:0] and flags in [7:4]
	function automatic logic [7:0] alu_model(input logic [3:0] op, input logic [1:0] opt,
		input nibble_t a, input nibble_t b, input nibble_t fl);
		int         t;
		logic [3:0] res;
		logic       c;
		logic       bw;
		c = 1'b0;
		bw = 1'b0;
		case (op)
			OP_ADD_INC: t = int'(a) + ((opt == 2'b10) ? 1 : int'(b));
			OP_ADC: t = int'(a) + int'(b) + int'(fl[FLAG_C]);
			OP_SUB_DEC: t = int'(a) - ((opt == 2'b11) ? 1 : int'(b));
			OP_SBB: t = int'(a) - int'(b) - int'(fl[FLAG_B]);
			OP_SHLR: t = (opt == 2'b01) ? int'(a >> 1) : int'(a) * 2;
			OP_NAND_NOR: t = int'((opt == 2'b10) ? ~(a | b) : ~(a & b));
			OP_AND_OR: t = int'((opt == 2'b10) ? (a | b) : (a & b));
			default: t = int'((opt == 2'b10) ? ~a : (a ^ b));
		endcase
		if (op == OP_ADD_INC || op == OP_ADC)
			c = (t > 15);
		if (op == OP_SUB_DEC || op == OP_SBB)
			bw = (t < 0);
		if (op == OP_SHLR)
			c = (opt == 2'b01) ? a[0] : a[3];
		res = t[3:0];
		return {res[3], (res == 4'd0), bw, c, res};
	endfunction

	// Runs the image up to the final jump and records all reads and stores
	function automatic void run_reference();
		nibble_t     r [8];
		logic [10:0] pc;
		logic [10:0] here;
		logic [10:0] ptr;
		logic [11:0] w;
		logic [3:0]  op;
		logic [1:0]  opt;
		logic [2:0]  dst;
		logic [7:0]  res;
		logic        one;
		logic        take;
		logic        done;
		for (int i = 0; i < 8; i++)
			r[i] = '0;
		pc = '0;
		w = '0;
		done = 1'b0;
		for (int n = 0; n < 5000 && !done; n++) begin
			here = pc;
			for (int k = 0; k < 3; k++) begin
				exp_reads.push_back(pc);
				w = {w[7:0], ref_mem[pc]};
				pc = pc + 11'd1;
			end
			op = w[11:8];
			opt = w[7:6];
			ptr = {r[6][2:0], r[5], r[4]};
			one = (op == OP_ADD_INC && opt == 2'b10) || (op == OP_SUB_DEC && opt == 2'b11) ||
				op == OP_SHLR || (op == OP_XOR_NOT && opt == 2'b10);
			take = 1'b0;
			case (op)
				OP_MOV: r[w[2:0]] = r[w[5:3]];
				OP_STO: begin
					ref_mem[ptr] = r[w[2:0]];
					exp_store_addr.push_back(ptr);
					exp_store_data.push_back(r[w[2:0]]);
				end
				OP_LD: begin
					exp_reads.push_back(ptr);
					r[w[2:0]] = ref_mem[ptr];
				end
				OP_JMP: take = 1'b1;
				OP_JNZ: take = !r[3][FLAG_Z];
				OP_JNC_JNB: take = (opt == 2'b10) ? !r[3][FLAG_B] : !r[3][FLAG_C];
				OP_JNL: take = !r[3][FLAG_N];
				OP_LDI: r[w[2:0]] = w[7:4];
				default: begin
					dst = one ? w[2:0] : w[5:3];
					res = alu_model(op, opt, r[dst], r[w[2:0]], r[3]);
					r[dst] = res[3:0];
					r[3] = res[7:4];   // Flags win over a result to r3
				end
			endcase
			if (take)
				pc = ptr;
			if (here == halt_addr)
				done = 1'b1;
		end
	endfunction

	task automatic check_value(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Ready and latency for the memory model
	initial begin
		rnd_ready = 1'b0;
		rnd_lat = 2'd0;
		forever begin
			@(posedge clk);
			#1;
			rnd_ready = (rand_nibble(2) != 4'd0);
			rnd_lat = 2'(rand_nibble(2));
		end
	end

	// Checks every accepted transfer against the reference
	initial begin
		forever begin
			@(negedge clk);
			if (log_valid && log_we) begin
				if (exp_store_addr.size() == 0) begin
					$display("Store at address %0h came after the last expected store",
						log_addr);
					$display("TESTS FAILED");
					$fatal(1);
				end else begin
					check_value("store address", int'(log_addr), int'(exp_store_addr[0]));
					check_value("store data", int'(log_data), int'(exp_store_data[0]));
					void'(exp_store_addr.pop_front());
					void'(exp_store_data.pop_front());
				end
			end else if (log_valid && exp_reads.size() != 0) begin
				check_value("read address", int'(log_addr), int'(exp_reads[0]));
				void'(exp_reads.pop_front());
			end
		end
	end

	initial begin
		rst_n = 1'b1;
		lfsr_q = 16'd29123;
		gen_program();
		for (int i = 0; i < 2048; i++) begin
			mem_i.mem_q[i] = img[i];
			ref_mem[i] = img[i];
		end
		run_reference();
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b0;
		cycles = 0;
		while ((exp_reads.size() != 0 || exp_store_addr.size() != 0) && cycles < 200000) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_reads.size() != 0 || exp_store_addr.size() != 0) begin
			$display("Timeout with %0d stores and %0d reads still expected",
				exp_store_addr.size(), exp_reads.size());
			$display("TESTS FAILED");
			$fatal(1);
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

// ==== tb.f ====
source/cpu_bus_pkg.sv
source/cpu_isa_pkg.sv
source/cpu_alu.sv
source/cpu_reg_file.sv
source/cpu_sequencer.sv
source/cpu_top.sv
dv/cpu_mem_model.sv
dv/tb_top.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the CPU testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_top -f tb.f -o Vtb_top

# The simulation status is judged from the log below
./obj_dir/Vtb_top | tee sim.log || true

if grep -q "TESTS FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi

if ! grep -q "TESTS PASSED" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi

echo "Simulation passed"
